//--- source/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// horizontal raster in pixel clocks
`define VID_H_ACTIVE 16
`define VID_H_FP 2
`define VID_H_SYNC 3
`define VID_H_BP 4
`define VID_H_TOTAL (`VID_H_ACTIVE + `VID_H_FP + `VID_H_SYNC + `VID_H_BP)

// vertical raster in lines
`define VID_V_ACTIVE 6
`define VID_V_FP 1
`define VID_V_SYNC 2
`define VID_V_BP 2
`define VID_V_TOTAL (`VID_V_ACTIVE + `VID_V_FP + `VID_V_SYNC + `VID_V_BP)

`define VID_HS_POL 1'b1 // positive hsync
`define VID_VS_POL 1'b1 // positive vsync

// pixel buffer entries, equal to the credits the source starts with
`define VID_FIFO_DEPTH 8

`endif

//--- source/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t; // frame source pixel

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } vsync_t;

    typedef struct packed {
        logic [5:0] pad; // unused
        logic       c1;
        logic       c0;
    } tmds_ctrl_t;

    // data byte during de, control pair in blanking
    typedef union packed {
        logic [7:0] data;
        tmds_ctrl_t ctrl;
    } tmds_in_u;

    typedef logic [9:0] tmds_word_t;

    // control tokens, suffix is {c1, c0}
    localparam tmds_word_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_word_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_word_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_word_t TMDS_CTRL_11 = 10'b1010101011;

endpackage

`default_nettype wire

//--- source/video_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_settings.svh"

module video_timing
    import video_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output vsync_t sync
);

    localparam int H_TOTAL = `VID_H_TOTAL;
    localparam int V_TOTAL = `VID_V_TOTAL;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // line layout is front porch, sync, back porch, active
    localparam int H_SYNC_BEG = `VID_H_FP;
    localparam int H_SYNC_END = `VID_H_FP + `VID_H_SYNC; // first count past sync
    localparam int H_ACT_BEG  = `VID_H_FP + `VID_H_SYNC + `VID_H_BP;

    // frame layout in lines, same order
    localparam int V_SYNC_BEG = `VID_V_FP;
    localparam int V_SYNC_END = `VID_V_FP + `VID_V_SYNC;
    localparam int V_ACT_BEG  = `VID_V_FP + `VID_V_SYNC + `VID_V_BP;

    logic [HW-1:0] h_cnt;    // pixel within line
    logic [VW-1:0] v_cnt;    // line within frame
    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_nxt;
    logic          h_wrap;   // last pixel of line
    logic          in_hsync;
    logic          in_vsync;
    vsync_t        sync_nxt;

    always_comb begin
        h_wrap = (h_cnt == HW'(H_TOTAL - 1));
        h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;
        v_nxt  = v_cnt;
        if (h_wrap) begin
            v_nxt = (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1; // frame wrap
        end

        // decode next counts so the flops hold the sync of the current count
        in_hsync    = (h_nxt >= HW'(H_SYNC_BEG)) && (h_nxt < HW'(H_SYNC_END));
        in_vsync    = (v_nxt >= VW'(V_SYNC_BEG)) && (v_nxt < VW'(V_SYNC_END));
        sync_nxt.hs = in_hsync ? `VID_HS_POL : ~`VID_HS_POL;
        sync_nxt.vs = in_vsync ? `VID_VS_POL : ~`VID_VS_POL;
        sync_nxt.de = (h_nxt >= HW'(H_ACT_BEG)) && (v_nxt >= VW'(V_ACT_BEG)); // to end of line
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            sync.hs <= ~`VID_HS_POL; // idle level
            sync.vs <= ~`VID_VS_POL;
            sync.de <= 1'b0;
        end else begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
            sync  <= sync_nxt;
        end
    end

endmodule

`default_nettype wire

//--- source/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_settings.svh"

module pixel_fifo
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    pix_valid,
    input  rgb565_t pix,
    input  logic    pop,
    output logic    credit,
    output rgb565_t rd_pix,
    output logic    underflow
);

    localparam int DEPTH = `VID_FIFO_DEPTH;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1); // holds 0..DEPTH

    rgb565_t       mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;  // occupancy
    logic          full;
    logic          empty;
    logic          wr_en;
    logic          rd_en;

    // circular increment, depth need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign wr_en = pix_valid && !full; // credits keep the source off a full buffer
    assign rd_en = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= pix;
        end
    end

    // black whenever nothing is read, including a pop on empty
    always_ff @(posedge clk) begin
        rd_pix <= rd_en ? mem[rd_ptr] : '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credit    <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count  <= count + CW'(wr_en) - CW'(rd_en);
            credit <= rd_en;    // one credit back per consumed pixel
            if (pop && empty) begin
                underflow <= 1'b1; // sticky
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pixel_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_settings.svh"

module pixel_align
    import video_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  vsync_t         raw_sync,
    input  rgb565_t        rd_pix,
    output vsync_t         sync,
    output tmds_in_u [2:0] ch_in    // [0] b, [1] g, [2] r
);

    localparam vsync_t SYNC_IDLE = '{hs: ~`VID_HS_POL, vs: ~`VID_VS_POL, de: 1'b0};

    vsync_t  sync_d1; // lines up with the fifo read data
    rgb888_t colour;  // expanded and blanked pixel

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_d1 <= SYNC_IDLE;
            sync    <= SYNC_IDLE;
        end else begin
            sync_d1 <= raw_sync;
            sync    <= sync_d1;
        end
    end

    // top bits repeated into the low bits so full scale maps to 8'hff
    always_ff @(posedge clk) begin
        if (sync_d1.de) begin
            colour.r <= {rd_pix.r, rd_pix.r[4:2]};
            colour.g <= {rd_pix.g, rd_pix.g[5:4]};
            colour.b <= {rd_pix.b, rd_pix.b[4:2]};
        end else begin
            colour <= '0; // blank outside active area
        end
    end

    always_comb begin
        if (sync.de) begin
            ch_in[0].data = colour.b;
            ch_in[1].data = colour.g;
            ch_in[2].data = colour.r;
        end else begin
            ch_in[0].ctrl = '{pad: '0, c1: sync.vs, c0: sync.hs}; // syncs ride on blue
            ch_in[1].ctrl = '0;
            ch_in[2].ctrl = '0;
        end
    end

endmodule

`default_nettype wire

//--- source/tmds_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       de,
    input  tmds_in_u   din,
    output tmds_word_t dout
);

    logic [7:0]        d;
    logic [3:0]        n1_d;     // ones in data byte
    logic [3:0]        n1_q;     // ones in q_m[7:0]
    logic              use_xnor;
    logic [8:0]        q_m;      // transition minimised word
    logic signed [5:0] bal;      // ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;     // running disparity
    logic signed [5:0] disp_nxt;
    tmds_word_t        word_nxt;
    tmds_word_t        ctrl_tok;

    always_comb begin
        d        = din.data;
        n1_d     = 4'($countones(d));
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d[0]);

        q_m[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = q_m[i-1] ^ d[i] ^ use_xnor; // xnor is xor with the flag set
        end
        q_m[8] = !use_xnor;

        n1_q = 4'($countones(q_m[7:0]));
        bal  = $signed(6'({n1_q, 1'b0}) - 6'd8); // 2*n1 - 8

        if ((disp == 6'sd0) || (bal == 6'sd0)) begin
            // no bias either way, bit 9 just flags the inversion
            word_nxt = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_nxt = q_m[8] ? disp + bal : disp - bal;
        end else if (((disp > 6'sd0) && (bal > 6'sd0)) ||
                     ((disp < 6'sd0) && (bal < 6'sd0))) begin
            word_nxt = {1'b1, q_m[8], ~q_m[7:0]}; // invert to pull disparity back
            disp_nxt = disp + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            word_nxt = {1'b0, q_m[8], q_m[7:0]};
            disp_nxt = disp - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_comb begin
        case ({din.ctrl.c1, din.ctrl.c0})
            2'b00:   ctrl_tok = TMDS_CTRL_00;
            2'b01:   ctrl_tok = TMDS_CTRL_01;
            2'b10:   ctrl_tok = TMDS_CTRL_10;
            default: ctrl_tok = TMDS_CTRL_11;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= TMDS_CTRL_00;
            disp <= '0;
        end else if (de) begin
            dout <= word_nxt;
            disp <= disp_nxt;
        end else begin
            dout <= ctrl_tok;
            disp <= '0; // balance restarts each blanking period
        end
    end

endmodule

`default_nettype wire

//--- source/video_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_out_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_valid,
    input  rgb565_t    pix,
    output logic       credit,
    output logic       underflow,
    output tmds_word_t tmds_b,
    output tmds_word_t tmds_g,
    output tmds_word_t tmds_r
);

    vsync_t         raw_sync;   // straight from the counters
    vsync_t         al_sync;    // two clocks later, matches colour
    rgb565_t        rd_pix;
    tmds_in_u [2:0] ch_in;

    video_timing video_timing_inst (
        .clk  (clk),
        .rst  (rst),
        .sync (raw_sync)
    );

    pixel_fifo pixel_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix       (pix),
        .pop       (raw_sync.de), // one pixel per active clock
        .credit    (credit),
        .rd_pix    (rd_pix),
        .underflow (underflow)
    );

    pixel_align pixel_align_inst (
        .clk      (clk),
        .rst      (rst),
        .raw_sync (raw_sync),
        .rd_pix   (rd_pix),
        .sync     (al_sync),
        .ch_in    (ch_in)
    );

    tmds_encoder tmds_encoder_b_inst (
        .clk  (clk),
        .rst  (rst),
        .de   (al_sync.de),
        .din  (ch_in[0]),
        .dout (tmds_b)
    );

    tmds_encoder tmds_encoder_g_inst (
        .clk  (clk),
        .rst  (rst),
        .de   (al_sync.de),
        .din  (ch_in[1]),
        .dout (tmds_g)
    );

    tmds_encoder tmds_encoder_r_inst (
        .clk  (clk),
        .rst  (rst),
        .de   (al_sync.de),
        .din  (ch_in[2]),
        .dout (tmds_r)
    );

endmodule

`default_nettype wire

//--- verif/video_out_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_settings.svh"

module video_out_assert #(
    parameter int DEPTH = `VID_FIFO_DEPTH,
    parameter int CW    = $clog2(`VID_FIFO_DEPTH + 1)
) (
    input logic          clk,
    input logic          rst,
    input logic          pix_valid,
    input logic          pop,
    input logic          credit,
    input logic          full,
    input logic [CW-1:0] count
);

    // occupancy never past the buffer size
    occupancy_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CW'(DEPTH))
        else $error("pixel fifo occupancy above depth");

    // credit is a pulse, gone once the pops stop
    credit_single_pulse: assert property (@(posedge clk) disable iff (rst)
        !pop |=> !credit)
        else $error("credit held past the pop that earned it");

    // source must stay off a full buffer
    no_beat_when_full: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> !full)
        else $error("pixel beat arrived while fifo full");

    // raw de holds for exactly one active line
    active_run_length: assert property (@(posedge clk) disable iff (rst)
        $rose(pop) |-> ##(`VID_H_ACTIVE) $fell(pop))
        else $error("raw de run differs from active line length");

endmodule

bind pixel_fifo video_out_assert video_out_assert_inst (
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix_valid),
    .pop       (pop),
    .credit    (credit),
    .full      (full),
    .count     (count)
);

`default_nettype wire

//--- verif/video_out_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_settings.svh"

module video_out_tb
    import video_pkg::*;
();

    localparam int FRAME     = `VID_H_TOTAL * `VID_V_TOTAL;              // 275 clocks
    localparam int DEPTH     = `VID_FIFO_DEPTH;
    localparam int N_STIM    = 10;
    localparam int PIX_TOTAL = 2 * `VID_V_ACTIVE * `VID_H_ACTIVE;       // two full frames
    localparam int LATENCY   = 3;                                       // raw sync to tmds
    localparam int END_N     = 3 * FRAME + 30 + LATENCY;                // past fourth vs edge
    localparam int TIMEOUT   = 16 + 3 * FRAME + 100;

    typedef struct packed {
        rgb565_t pix;
        rgb888_t exp;  // hand expanded
    } stim_t;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       pix_valid;
    rgb565_t    pix;
    logic       credit;
    logic       underflow;
    tmds_word_t tmds_b;
    tmds_word_t tmds_g;
    tmds_word_t tmds_r;

    stim_t   stim [N_STIM];
    int      errors = 0;
    int      checks = 0;
    int      credits = DEPTH;  // source side credit count
    int      sent = 0;
    int      returned = 0;
    logic    gap;
    int      n = 0;            // output cycle since reset release
    int      m;                // raster count behind the output
    int      pk = 0;           // next expected table pixel
    int      run = 0;          // data words in current line
    int      lines = 0;
    int      vs_edges = 0;
    int      last_vs = -1;
    logic    prev_vs = 1'b0;
    logic    blue_vs;
    int      bal [3];
    logic    done = 1'b0;
    int      cycles = 0;
    vsync_t  exp_s;
    rgb888_t exp_c;

    video_out_top video_out_top_inst (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix       (pix),
        .credit    (credit),
        .underflow (underflow),
        .tmds_b    (tmds_b),
        .tmds_g    (tmds_g),
        .tmds_r    (tmds_r)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, n);
        end
    endtask

    // dvi control words by value
    function automatic tmds_word_t ctrl_token(input logic c1, input logic c0);
        case ({c1, c0})
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic is_token(input tmds_word_t w);
        return (w == ctrl_token(1'b0, 1'b0)) || (w == ctrl_token(1'b0, 1'b1)) ||
               (w == ctrl_token(1'b1, 1'b0)) || (w == ctrl_token(1'b1, 1'b1));
    endfunction

    // receiver side decode of a data word
    function automatic logic [7:0] tmds_decode(input tmds_word_t w);
        logic [7:0] q;
        logic [7:0] d;
        q    = w[9] ? ~w[7:0] : w[7:0];  // undo inversion
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    // expected raw sync for raster count c, idle before the first count
    function automatic vsync_t raster_at(input int c);
        int     h;
        int     v;
        logic   in_hs;
        logic   in_vs;
        vsync_t s;
        h     = (c < 0) ? 0 : c % `VID_H_TOTAL;
        v     = (c < 0) ? 0 : (c / `VID_H_TOTAL) % `VID_V_TOTAL;
        in_hs = (h >= `VID_H_FP) && (h < `VID_H_FP + `VID_H_SYNC);
        in_vs = (v >= `VID_V_FP) && (v < `VID_V_FP + `VID_V_SYNC);
        s.hs  = in_hs ? `VID_HS_POL : ~`VID_HS_POL;
        s.vs  = in_vs ? `VID_VS_POL : ~`VID_VS_POL;
        s.de  = (h >= `VID_H_FP + `VID_H_SYNC + `VID_H_BP) &&
                (v >= `VID_V_FP + `VID_V_SYNC + `VID_V_BP);
        return s;
    endfunction

    task automatic check_channel(input string name, input int idx, input tmds_word_t w,
                                 input logic [7:0] exp);
        int ones;
        ones = $countones(w);
        check(name, 32'(tmds_decode(w)), 32'(exp));
        bal[idx] = bal[idx] + 2 * ones - 10;  // ones minus zeros
        check({name, "_dc_in_range"}, 32'((bal[idx] >= -10) && (bal[idx] <= 10)), 32'd1);
    endtask

    // credit honouring source, gaps only when the buffer is well stocked
    always @(posedge clk) begin
        if (!rst) begin
            if (credit) begin
                credits = credits + 1;
                returned++;
            end
            gap = (($urandom % 4) == 0) && (credits < 3);
            if ((credits > 0) && (sent < PIX_TOTAL) && !gap) begin
                pix_valid <= 1'b1;
                pix       <= stim[sent % N_STIM].pix;
                credits   = credits - 1;
                sent++;
            end else begin
                pix_valid <= 1'b0;
            end
            check("source_credits_in_range", 32'((credits >= 0) && (credits <= DEPTH)), 32'd1);
        end
    end

    // output checks at the falling edge, words stable there
    always @(negedge clk) begin
        if (!rst && !done) begin
            m     = n - LATENCY;
            exp_s = raster_at(m);
            if (exp_s.de) begin
                exp_c = ((m / FRAME) < 2) ? stim[pk % N_STIM].exp : '0; // black on underflow
                if ((m / FRAME) < 2) begin
                    pk++;
                end
                check_channel("tmds_b", 0, tmds_b, exp_c.b);
                check_channel("tmds_g", 1, tmds_g, exp_c.g);
                check_channel("tmds_r", 2, tmds_r, exp_c.r);
            end else begin
                check("tmds_b", 32'(tmds_b), 32'(ctrl_token(exp_s.vs, exp_s.hs)));
                check("tmds_g", 32'(tmds_g), 32'(ctrl_token(1'b0, 1'b0)));
                check("tmds_r", 32'(tmds_r), 32'(ctrl_token(1'b0, 1'b0)));
                bal[0] = 0; // balance restarts in blanking
                bal[1] = 0;
                bal[2] = 0;
            end

            // raster seen purely from the blue words
            if (!is_token(tmds_b)) begin
                run++;
            end else if (run != 0) begin
                check("line_data_words", 32'(run), 32'(`VID_H_ACTIVE));
                lines++;
                run = 0;
            end
            blue_vs = (tmds_b == ctrl_token(1'b1, 1'b0)) || (tmds_b == ctrl_token(1'b1, 1'b1));
            if (blue_vs && !prev_vs) begin
                if (last_vs >= 0) begin
                    check("frame_clocks", 32'(n - last_vs), 32'(FRAME));
                    check("frame_lines", 32'(lines), 32'(`VID_V_ACTIVE));
                end
                lines   = 0;
                last_vs = n;
                vs_edges++;
            end
            prev_vs = blue_vs;

            if (n < 2 * FRAME) begin
                check("underflow", 32'(underflow), 32'd0);
            end
            n++;
            if (n == END_N) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(32'h7a7f67c4));
        stim[0] = {16'h0000, 24'h000000};
        stim[1] = {16'hffff, 24'hffffff}; // full scale
        stim[2] = {16'hf800, 24'hff0000};
        stim[3] = {16'h07e0, 24'h00ff00};
        stim[4] = {16'h001f, 24'h0000ff};
        stim[5] = {16'h8410, 24'h848284}; // mid grey
        stim[6] = {16'h0821, 24'h080408}; // lsb only
        stim[7] = {16'h7aaa, 24'h7b5552};
        stim[8] = {16'had55, 24'hadaaad};
        stim[9] = {16'he183, 24'he73018};
        bal[0]    = 0;
        bal[1]    = 0;
        bal[2]    = 0;
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix       = '0;

        repeat (16) @(posedge clk);
        cycles = 16;
        rst <= 1'b0;
        while (!done && (cycles < TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end

        if (!done) begin
            errors++;
            $display("timeout after %0d cycles, raster checks never completed", cycles);
        end else begin
            check("underflow", 32'(underflow), 32'd1);
            check("credits_returned", 32'(returned), 32'(PIX_TOTAL));
            check("source_credits", 32'(credits), 32'(DEPTH));
            check("vs_edges", 32'(vs_edges), 32'd4);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/video_pkg.sv
source/video_timing.sv
source/pixel_fifo.sv
source/pixel_align.sv
source/tmds_encoder.sv
source/video_out_top.sv
verif/video_out_assert.sv
verif/video_out_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module video_out_tb -f vlog.f -o video_out_sim

out=$(./obj_dir/video_out_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
